// ==== verilog/nes_loader_pkg.sv ====
// iNES cartridge loader shared definitions
// Memory map, header constants and the structs passed between stages

package nes_loader_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Memory map
	////////////////////////////////////////////////////////////////////////////

	localparam int addr_width    = 22;
	localparam int prg_page_bits = 14;  // 16 KiB PRG pages
	localparam int chr_page_bits = 13;  // 8 KiB CHR pages

	// CHR ROM sits in the upper half of the cartridge space
	localparam logic [addr_width-1:0] chr_base = 22'h20_0000;

	////////////////////////////////////////////////////////////////////////////
	// Header
	////////////////////////////////////////////////////////////////////////////

	localparam int header_len = 16;

	// "NES" followed by MS-DOS end of file
	localparam logic [31:0] ines_magic = 32'h4E45_531A;

	////////////////////////////////////////////////////////////////////////////
	// Stage payloads
	////////////////////////////////////////////////////////////////////////////

	// One byte placed in cartridge memory
	typedef struct packed {
		logic [addr_width-1:0] addr;
		logic [7:0]            data;
	} mem_write_t;

	// Page counts straight from header bytes 4 and 5
	typedef struct packed {
		logic [7:0] prg_pages;
		logic [7:0] chr_pages;
	} rom_sizes_t;

	// Cartridge description handed to the NES core
	typedef struct packed {
		logic       has_saves;    // Battery backed RAM
		logic [7:0] submapper;    // NES 2.0 only
		logic       four_screen;
		logic       chr_ram;      // No CHR ROM in the image
		logic       mirroring;    // 1 = vertical
		logic [2:0] chr_size;     // Log2 of 8 KiB pages, 7 = larger
		logic [2:0] prg_size;     // Log2 of 16 KiB pages, 7 = larger
		logic [7:0] mapper;
	} mapper_flags_t;

endpackage

// ==== verilog/req_ack_stage.sv ====
// One-entry holding stage between handshake domains
// Either side speaks four-phase req/ack or a one-cycle valid/take

module req_ack_stage #(
	parameter type payload_t       = logic [7:0],
	parameter bit  up_four_phase   = 1'b1,  // 0 selects valid/take upstream
	parameter bit  down_four_phase = 1'b0   // 0 selects valid/take downstream
) (
	input  logic     clk,
	input  logic     reset_nes,
	input  logic     up_req,     // Req, or valid
	input  payload_t up_data,
	output logic     up_ack,     // Ack, or take pulse
	output logic     down_req,   // Req, or valid
	output payload_t down_data,
	input  logic     down_ack    // Ack, or take pulse
);
	logic     full;
	logic     accept;
	logic     drain;
	payload_t held;

	always_ff @(posedge clk) begin
		if (reset_nes)
			full <= 1'b0;
		else if (accept)
			full <= 1'b1;
		else if (drain)
			full <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (accept)
			held <= up_data;
	end

	assign down_data = held;

	generate
		if (up_four_phase) begin : g_up_req_ack
			logic up_phase;  // High from ack until req seen low

			assign accept = up_req && !full && !up_phase;
			assign up_ack = up_phase;

			always_ff @(posedge clk) begin
				if (reset_nes)
					up_phase <= 1'b0;
				else if (accept)
					up_phase <= 1'b1;
				else if (up_phase && !up_req)
					up_phase <= 1'b0;
			end
		end else begin : g_up_valid_take
			assign accept = up_req && !full;
			assign up_ack = accept;
		end

		if (down_four_phase) begin : g_down_req_ack
			logic req_q;
			logic down_phase;  // Ack seen, waiting for it to drop

			assign down_req = req_q;
			assign drain    = down_phase && !down_ack;

			always_ff @(posedge clk) begin
				if (reset_nes) begin
					req_q      <= 1'b0;
					down_phase <= 1'b0;
				end else if (accept) begin
					req_q <= 1'b1;
				end else if (req_q && down_ack) begin
					req_q      <= 1'b0;
					down_phase <= 1'b1;
				end else if (drain) begin
					down_phase <= 1'b0;
				end
			end
		end else begin : g_down_valid_take
			assign down_req = full;
			assign drain    = full && down_ack;
		end
	endgenerate

endmodule

// ==== verilog/ines_header_parser.sv ====
// iNES header parser
// Collects the 16 header bytes, checks magic and trainer, decodes the
// mapper flags, then forwards PRG/CHR bytes or swallows them on error

module ines_header_parser (
	input  logic                          clk,
	input  logic                          reset_nes,
	input  logic                          byte_valid,
	input  logic [7:0]                    byte_data,
	output logic                          byte_take,
	input  logic                          invert_mirroring,
	output logic                          rom_valid,
	output logic [7:0]                    rom_data,
	input  logic                          rom_take,
	output nes_loader_pkg::rom_sizes_t    sizes,
	output logic                          sizes_valid,
	output nes_loader_pkg::mapper_flags_t flags,
	output logic                          error
);
	import nes_loader_pkg::*;

	localparam int cnt_bits = $clog2(header_len);

	typedef enum logic [1:0] {
		st_header,
		st_rom,
		st_error
	} state_t;

	state_t              state;
	logic [cnt_bits-1:0] count;
	logic [7:0]          hdr [header_len];
	logic                header_ok;
	logic                is_nes20;
	logic                is_dirty;

	// Smallest k with pages <= 2**k, 7 when above 64 pages
	function automatic logic [2:0] size_code(input logic [7:0] pages);
		logic [2:0] code;
		code = 3'd7;
		for (int k = 6; k >= 0; k--) begin
			if (pages <= (8'd1 << k))
				code = 3'(k);
		end
		return code;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Header capture
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (state == st_header && byte_valid)
			hdr[count] <= byte_data;
	end

	// Bytes 0 to 6 are already stored when the last byte arrives
	assign header_ok = ({hdr[0], hdr[1], hdr[2], hdr[3]} == ines_magic)
		&& !hdr[6][2];  // Trainers not supported

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			state <= st_header;
			count <= '0;
		end else if (state == st_header && byte_valid) begin
			count <= count + 1'b1;
			if (count == cnt_bits'(header_len - 1))
				state <= header_ok ? st_rom : st_error;
		end
	end

	assign sizes_valid = (state == st_rom);
	assign error       = (state == st_error);

	////////////////////////////////////////////////////////////////////////////
	// Byte routing
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		case (state)
			st_rom:  byte_take = rom_take;    // Paced by the sequencer
			default: byte_take = byte_valid;  // Header, or discard after error
		endcase
	end

	assign rom_valid = (state == st_rom) && byte_valid;
	assign rom_data  = byte_data;

	////////////////////////////////////////////////////////////////////////////
	// Flag decoding
	////////////////////////////////////////////////////////////////////////////

	assign is_nes20 = (hdr[7][3:2] == 2'b10);

	// Old dumps often carry junk in the padding bytes
	assign is_dirty = !is_nes20 && ((hdr[9][7:1] != '0)
		|| (hdr[10] != '0) || (hdr[11] != '0) || (hdr[12] != '0)
		|| (hdr[13] != '0) || (hdr[14] != '0) || (hdr[15] != '0));

	always_comb begin
		flags.has_saves   = hdr[6][1];
		flags.submapper   = is_nes20 ? hdr[8] : 8'h00;
		flags.four_screen = hdr[6][3];
		flags.chr_ram     = (hdr[5] == 8'h00);
		flags.mirroring   = hdr[6][0] ^ invert_mirroring;
		flags.chr_size    = size_code(hdr[5]);
		flags.prg_size    = size_code(hdr[4]);
		flags.mapper      = {is_dirty ? 4'h0 : hdr[7][7:4], hdr[6][7:4]};
	end

	assign sizes.prg_pages = hdr[4];
	assign sizes.chr_pages = hdr[5];

endmodule

// ==== verilog/rom_address_sequencer.sv ====
// ROM address sequencer
// Pairs each PRG byte with an address from 0 and each CHR byte with an
// address from the CHR base, then flags done once memory has drained

module rom_address_sequencer (
	input  logic                       clk,
	input  logic                       reset_nes,
	input  logic                       rom_valid,
	input  logic [7:0]                 rom_data,
	output logic                       rom_take,
	input  nes_loader_pkg::rom_sizes_t sizes,
	input  logic                       sizes_valid,
	output logic                       write_valid,
	output nes_loader_pkg::mem_write_t write,
	input  logic                       write_take,
	input  logic                       write_idle,
	output logic                       busy,
	output logic                       done
);
	import nes_loader_pkg::*;

	typedef enum logic [1:0] {
		ph_prg,
		ph_chr,
		ph_finish
	} phase_t;

	phase_t                phase;
	logic [addr_width-1:0] bytes_left;
	logic [addr_width-1:0] addr;
	logic                  have_bytes;

	assign have_bytes = (bytes_left != '0);

	// Hand-off register and output stage must both be free
	assign rom_take = busy && (phase != ph_finish) && have_bytes && rom_valid
		&& !write_valid && write_idle;

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			phase       <= ph_prg;
			bytes_left  <= '0;
			addr        <= '0;
			write_valid <= 1'b0;
			busy        <= 1'b0;
			done        <= 1'b0;
		end else begin
			if (write_take)
				write_valid <= 1'b0;

			if (!busy) begin
				if (sizes_valid && !done) begin  // Good header just parsed
					busy       <= 1'b1;
					phase      <= ph_prg;
					bytes_left <= addr_width'(sizes.prg_pages) << prg_page_bits;
					addr       <= '0;
				end
			end else begin
				if (rom_take) begin
					write_valid <= 1'b1;
					bytes_left  <= bytes_left - 1'b1;
					addr        <= addr + 1'b1;
				end

				case (phase)
					ph_prg: if (!have_bytes) begin
						phase      <= ph_chr;
						bytes_left <= addr_width'(sizes.chr_pages) << chr_page_bits;
						addr       <= chr_base;
					end
					ph_chr: if (!have_bytes)
						phase <= ph_finish;
					default: if (!write_valid && write_idle) begin
						busy <= 1'b0;  // Last write has left memory
						done <= 1'b1;
					end
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rom_take) begin
			write.addr <= addr;
			write.data <= rom_data;
		end
	end

endmodule

// ==== verilog/cart_loader.sv ====
// NES cartridge loader top level
// Input stage, header parser, address sequencer and memory write stage

module cart_loader (
	input  logic                          clk,
	input  logic                          reset_nes,
	input  logic                          in_req,
	input  logic [7:0]                    in_data,
	output logic                          in_ack,
	input  logic                          invert_mirroring,
	output logic                          mem_req,
	output nes_loader_pkg::mem_write_t    mem_write,
	input  logic                          mem_ack,
	output nes_loader_pkg::mapper_flags_t flags,
	output logic                          busy,
	output logic                          done,
	output logic                          error
);
	import nes_loader_pkg::*;

	logic       byte_valid;
	logic [7:0] byte_data;
	logic       byte_take;
	logic       rom_valid;
	logic [7:0] rom_data;
	logic       rom_take;
	rom_sizes_t sizes;
	logic       sizes_valid;
	logic       write_valid;
	mem_write_t write;
	logic       write_take;
	logic       write_idle;
	logic       seq_done;

	req_ack_stage #(
		.payload_t       (logic [7:0]),
		.up_four_phase   (1'b1),
		.down_four_phase (1'b0)
	) u_in_stage (
		.clk       (clk),
		.reset_nes (reset_nes),
		.up_req    (in_req),
		.up_data   (in_data),
		.up_ack    (in_ack),
		.down_req  (byte_valid),
		.down_data (byte_data),
		.down_ack  (byte_take)
	);

	ines_header_parser u_parser (
		.clk              (clk),
		.reset_nes        (reset_nes),
		.byte_valid       (byte_valid),
		.byte_data        (byte_data),
		.byte_take        (byte_take),
		.invert_mirroring (invert_mirroring),
		.rom_valid        (rom_valid),
		.rom_data         (rom_data),
		.rom_take         (rom_take),
		.sizes            (sizes),
		.sizes_valid      (sizes_valid),
		.flags            (flags),
		.error            (error)
	);

	rom_address_sequencer u_sequencer (
		.clk         (clk),
		.reset_nes   (reset_nes),
		.rom_valid   (rom_valid),
		.rom_data    (rom_data),
		.rom_take    (rom_take),
		.sizes       (sizes),
		.sizes_valid (sizes_valid),
		.write_valid (write_valid),
		.write       (write),
		.write_take  (write_take),
		.write_idle  (write_idle),
		.busy        (busy),
		.done        (seq_done)
	);

	req_ack_stage #(
		.payload_t       (mem_write_t),
		.up_four_phase   (1'b0),
		.down_four_phase (1'b1)
	) u_out_stage (
		.clk       (clk),
		.reset_nes (reset_nes),
		.up_req    (write_valid),
		.up_data   (write),
		.up_ack    (write_take),
		.down_req  (mem_req),
		.down_data (mem_write),
		.down_ack  (mem_ack)
	);

	// No write outstanding on the memory port
	assign write_idle = !mem_req && !mem_ack;

	assign done = seq_done || error;

endmodule

// ==== verification/clock_gen.sv ====
// Testbench clock and reset source
// Period of 4 time units, reset held for the first 8 rising edges

module clock_gen (
	output logic clk,
	output logic reset_init
);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	initial begin
		reset_init = 1'b1;
		repeat (8) @(posedge clk);
		@(negedge clk);  // Release away from the sampling edge
		reset_init = 1'b0;
	end

endmodule

// ==== verification/cart_loader_asserts.sv ====
// Handshake and status properties of the cartridge loader
// Bound into every cart_loader instance

module cart_loader_asserts (
	input logic                       clk,
	input logic                       reset_nes,
	input logic                       in_ack,
	input logic                       mem_req,
	input logic                       mem_ack,
	input nes_loader_pkg::mem_write_t mem_write,
	input logic                       busy,
	input logic                       done,
	input logic                       error
);

	// Request stays up until memory answers
	a_req_hold: assert property (@(posedge clk) disable iff (reset_nes)
		mem_req && !mem_ack |=> mem_req)
		else $error("mem_req dropped before mem_ack");

	a_write_stable: assert property (@(posedge clk) disable iff (reset_nes)
		mem_req && $past(mem_req) |-> $stable(mem_write))
		else $error("mem_write changed during a request");

	a_ack_reset: assert property (@(posedge clk)
		reset_nes |=> !in_ack)
		else $error("in_ack high after reset");

	// A bad header ends the load before the sequencer starts or any write goes out
	a_error_done: assert property (@(posedge clk) disable iff (reset_nes)
		error |-> done && !busy && !mem_req)
		else $error("error without done, or with a load still running");

endmodule

bind cart_loader cart_loader_asserts u_asserts (
	.clk       (clk),
	.reset_nes (reset_nes),
	.in_ack    (in_ack),
	.mem_req   (mem_req),
	.mem_ack   (mem_ack),
	.mem_write (mem_write),
	.busy      (busy),
	.done      (done),
	.error     (error)
);

// ==== verification/cart_loader_tb.sv ====
// Testbench for the NES cartridge loader
// Feeds iNES images byte by byte, models the cartridge memory and checks
// every write, the mapper flags and the done/error/busy status

module cart_loader_tb;
	import nes_loader_pkg::*;

	localparam int prg_bytes   = 1 << prg_page_bits;
	localparam int chr_bytes   = 1 << chr_page_bits;
	localparam int flag_count  = 9;
	localparam int total_bytes = 2 * (16 + prg_bytes + chr_bytes) + flag_count * 16
		+ 2 * (16 + 20) + 16 + prg_bytes;
	localparam int cycle_limit = 40 * total_bytes + 2000;

	// Page counts chosen to reach every size code
	localparam logic [7:0] prg_list [flag_count] = '{1, 2, 3, 8, 9, 32, 50, 200, 0};
	localparam logic [7:0] chr_list [flag_count] = '{0, 200, 33, 17, 5, 2, 1, 0, 0};

	logic          clk;
	logic          reset_init;
	logic          reset_force;
	logic          reset_nes;
	logic          in_req;
	logic [7:0]    in_data;
	logic          in_ack;
	logic          invert_mirroring;
	logic          mem_req;
	mem_write_t    mem_write;
	logic          mem_ack;
	mapper_flags_t flags;
	logic          busy;
	logic          done;
	logic          error;

	logic [31:0] data_lfsr = 32'hed56_39c5;
	logic [31:0] mem_lfsr  = 32'hed56_39c5;
	string       test_name = "reset";
	mem_write_t  exp_q [$];
	mem_write_t  got_q [$];
	int          write_count = 0;
	int          cycles = 0;
	bit          mem_random = 1'b0;
	logic [127:0] hdr;

	assign reset_nes = reset_init || reset_force;

	clock_gen u_clock (
		.clk        (clk),
		.reset_init (reset_init)
	);

	cart_loader uut (
		.clk              (clk),
		.reset_nes        (reset_nes),
		.in_req           (in_req),
		.in_data          (in_data),
		.in_ack           (in_ack),
		.invert_mirroring (invert_mirroring),
		.mem_req          (mem_req),
		.mem_write        (mem_write),
		.mem_ack          (mem_ack),
		.flags            (flags),
		.busy             (busy),
		.done             (done),
		.error            (error)
	);

	////////////////////////////////////////////////////////////////////////////
	// Random numbers and reference model
	////////////////////////////////////////////////////////////////////////////

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	task automatic rand_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			data_lfsr = lfsr_next(data_lfsr);
			v = {v[30:0], data_lfsr[0]};
		end
	endtask

	task automatic rand_byte(output logic [7:0] b);
		logic [31:0] v;
		rand_bits(8, v);
		b = v[7:0];
	endtask

	function automatic logic [2:0] ref_size_code(input logic [7:0] pages);
		for (int k = 0; k < 7; k++) begin
			if (int'(pages) <= (1 << k))
				return 3'(k);
		end
		return 3'd7;
	endfunction

	// Expected mapper flags of a header with byte i at bits 8*i and up
	function automatic mapper_flags_t ref_flags(input logic [127:0] h, input logic inv);
		logic [7:0]    b [16];
		logic          nes20;
		logic          dirty;
		mapper_flags_t f;
		for (int i = 0; i < 16; i++)
			b[i] = h[8*i +: 8];
		nes20 = (b[7][3:2] == 2'b10);
		dirty = !nes20 && ((b[9][7:1] != 7'd0) || (h[127:80] != '0));
		f.has_saves   = b[6][1];
		f.submapper   = nes20 ? b[8] : 8'd0;
		f.four_screen = b[6][3];
		f.chr_ram     = (b[5] == 8'd0);
		f.mirroring   = b[6][0] ^ inv;
		f.chr_size    = ref_size_code(b[5]);
		f.prg_size    = ref_size_code(b[4]);
		f.mapper      = {dirty ? 4'd0 : b[7][7:4], b[6][7:4]};
		return f;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////////////////////

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			$display("** Error [%s] %s: expected %h, actual %h", test_name, name,
				expected, actual);
			$display("SOME TESTS FAILED");
			$fatal(1);
		end
	endtask

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("Run stopped: no progress within %0d cycles in %s", cycle_limit,
				test_name);
			$display("SOME TESTS FAILED");
			$fatal(1);
		end
	end

	// Memory model that acks after 0 to 3 cycles
	initial begin
		int d;
		mem_ack = 1'b0;
		forever begin
			@(negedge clk);
			if (mem_req && !mem_ack && !reset_nes) begin
				d = 0;
				if (mem_random) begin
					mem_lfsr = lfsr_next(mem_lfsr);
					d = int'(mem_lfsr[0]);
					mem_lfsr = lfsr_next(mem_lfsr);
					d = d * 2 + int'(mem_lfsr[0]);
				end
				repeat (d) @(negedge clk);
				got_q.push_back(mem_write);
				write_count++;
				mem_ack = 1'b1;
				while (mem_req)
					@(negedge clk);
				mem_ack = 1'b0;
			end
		end
	end

	// Compares each recorded write with the next expected one
	always @(negedge clk) begin
		mem_write_t got;
		mem_write_t exp;
		while (got_q.size() > 0) begin
			got = got_q.pop_front();
			if (exp_q.size() == 0) begin
				$display("Test %s: memory write at %h that no byte asked for", test_name,
					got.addr);
				$display("SOME TESTS FAILED");
				$fatal(1);
			end
			exp = exp_q.pop_front();
			check_value("write address", 32'(exp.addr), 32'(got.addr));
			check_value("write data", 32'(exp.data), 32'(got.data));
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////////////////////

	task automatic send_byte(input logic [7:0] b);
		@(negedge clk);
		while (in_ack)
			@(negedge clk);
		in_data = b;
		in_req  = 1'b1;
		while (!in_ack)
			@(negedge clk);
		in_req = 1'b0;
	endtask

	task automatic send_header(input logic [127:0] h);
		for (int i = 0; i < 16; i++)
			send_byte(h[8*i +: 8]);
	endtask

	// Random header with good magic and no trainer
	task automatic make_header(output logic [127:0] h, input logic [7:0] prg,
		input logic [7:0] chr);
		logic [31:0] v;
		for (int i = 0; i < 4; i++) begin
			rand_bits(32, v);
			h[32*i +: 32] = v;
		end
		h[31:0]  = {ines_magic[7:0], ines_magic[15:8], ines_magic[23:16], ines_magic[31:24]};
		h[39:32] = prg;
		h[47:40] = chr;
		h[50]    = 1'b0;
	endtask

	task automatic send_rom(input logic [7:0] prg, input logic [7:0] chr);
		mem_write_t w;
		logic [7:0] b;
		for (int i = 0; i < int'(prg) * prg_bytes; i++) begin
			rand_byte(b);
			w.addr = addr_width'(i);
			w.data = b;
			exp_q.push_back(w);
			send_byte(b);
		end
		for (int i = 0; i < int'(chr) * chr_bytes; i++) begin
			rand_byte(b);
			w.addr = chr_base + addr_width'(i);
			w.data = b;
			exp_q.push_back(w);
			send_byte(b);
		end
	endtask

	task automatic wait_done();
		while (!done)
			@(negedge clk);
	endtask

	task automatic wait_header();
		while (!busy && !done)
			@(negedge clk);
	endtask

	task automatic apply_reset();
		@(negedge clk);
		reset_force = 1'b1;
		repeat (8) @(negedge clk);
		reset_force = 1'b0;
		@(negedge clk);
		write_count = 0;
	endtask

	task automatic check_drained(input int writes);
		repeat (2) @(negedge clk);
		check_value("pending writes", 32'd0, 32'(exp_q.size()));
		check_value("write count", 32'(writes), 32'(write_count));
	endtask

	// Complete image and then all status outputs
	task automatic full_image(input logic [7:0] prg, input logic [7:0] chr);
		make_header(hdr, prg, chr);
		send_header(hdr);
		wait_header();
		check_value("busy", 32'd1, 32'(busy));
		check_value("flags", 32'(ref_flags(hdr, invert_mirroring)), 32'(flags));
		send_rom(prg, chr);
		wait_done();
		check_value("error", 32'd0, 32'(error));
		check_value("busy after done", 32'd0, 32'(busy));
		check_drained(int'(prg) * prg_bytes + int'(chr) * chr_bytes);
	endtask

	task automatic bad_image(input int kind);
		logic [7:0] b;
		apply_reset();
		check_value("error after reset", 32'd0, 32'(error));
		make_header(hdr, 8'd1, 8'd1);
		if (kind == 0)
			hdr[7:0] = 8'h4D;
		else
			hdr[50] = 1'b1;  // Trainer present
		send_header(hdr);
		wait_done();
		check_value("error", 32'd1, 32'(error));
		for (int i = 0; i < 20; i++) begin
			rand_byte(b);
			send_byte(b);
		end
		check_value("done", 32'd1, 32'(done));
		check_drained(0);
	endtask

	initial begin
		in_req           = 1'b0;
		in_data          = 8'h00;
		invert_mirroring = 1'b0;
		reset_force      = 1'b0;
		@(negedge clk);
		while (reset_init)
			@(negedge clk);
		check_value("in_ack", 32'd0, 32'(in_ack));
		check_value("mem_req", 32'd0, 32'(mem_req));
		check_value("done", 32'd0, 32'(done));
		check_value("error", 32'd0, 32'(error));
		check_value("busy", 32'd0, 32'(busy));

		test_name = "valid image";
		full_image(8'd1, 8'd1);

		test_name = "flag decoding";
		for (int i = 0; i < flag_count; i++) begin
			apply_reset();
			invert_mirroring = i[0];
			make_header(hdr, prg_list[i], chr_list[i]);
			hdr[59:58] = (i % 2 == 0) ? 2'b10 : 2'b00;  // NES 2.0 on even entries
			if (i == 3)
				hdr[127:72] = '0;  // Clean iNES 1.0 padding
			send_header(hdr);
			wait_header();
			check_value("error", 32'd0, 32'(error));
			check_value("flags", 32'(ref_flags(hdr, invert_mirroring)), 32'(flags));
			if (i == flag_count - 1) begin
				wait_done();
				check_drained(0);
			end
		end
		invert_mirroring = 1'b0;

		test_name = "bad magic";
		bad_image(0);
		test_name = "trainer";
		bad_image(1);

		test_name = "back-pressure";
		apply_reset();
		mem_random = 1'b1;
		full_image(8'd1, 8'd1);

		test_name = "reset between images";
		apply_reset();
		check_value("done", 32'd0, 32'(done));
		check_value("error", 32'd0, 32'(error));
		check_value("busy", 32'd0, 32'(busy));
		full_image(8'd1, 8'd0);

		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

// ==== build.f ====
verilog/nes_loader_pkg.sv
verilog/req_ack_stage.sv
verilog/ines_header_parser.sv
verilog/rom_address_sequencer.sv
verilog/cart_loader.sv
verification/clock_gen.sv
verification/cart_loader_asserts.sv
verification/cart_loader_tb.sv

// ==== Makefile ====
# Verilator flow for the cartridge loader testbench

TOP = cart_loader_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f build.f --top-module $(TOP)

obj_dir/V$(TOP): build.f $(shell cat build.f)
	verilator --binary --timing --assert -f build.f --top-module $(TOP)

sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
